/* Makefile */
OBJ_DIR = obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module flight_ctrl_tb -Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/Vflight_ctrl_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only -Wall -f vlog.f --top-module flight_ctrl_top

clean:
	rm -rf $(OBJ_DIR)

/* design/angle_controller.sv */
// angle controller: latches receiver targets and IMU attitude on start,
// then maps, scales and limits them into one rate setpoint record
// and writes it out as a Wishbone classic write master
`default_nettype none

module angle_controller (
	input  wire logic                  us_clk,
	input  wire logic                  resetn,
	input  wire logic                  start,
	input  wire flight_pkg::target_t   targets,
	input  wire flight_pkg::attitude_t attitude,
	output flight_pkg::wb_req_t        wr_req,
	input  wire flight_pkg::wb_rsp_t   wr_rsp,
	output logic                       busy
);

	typedef enum logic [2:0] {
		ST_WAITING,
		ST_MAPPING,
		ST_SCALING,
		ST_LIMITING,
		ST_WRITING
	} state_t;

	state_t state;

	flight_pkg::target_t   tgt_q;
	flight_pkg::attitude_t att_q;

	// mapped values kept wide so extreme IMU angles cannot wrap
	logic signed [31:0] map_thr, map_yaw, map_pitch, map_roll;
	flight_pkg::rate_set_t scaled_q;
	flight_pkg::rate_set_t limit_q;

	// multiply, arithmetic shift, saturate to 16 bits
	function automatic flight_pkg::rate_t scale_sat(
		input logic signed [31:0] val,
		input int                 mult,
		input int                 shift
	);
		logic signed [31:0] prod;
		prod = (val * mult) >>> shift;
		if (prod > 32'sd32767)
			return 16'sh7fff;
		else if (prod < -32'sd32768)
			return 16'sh8000;
		else
			return prod[15:0];
	endfunction

	function automatic flight_pkg::rate_t clamp_rate(
		input flight_pkg::rate_t val,
		input flight_pkg::rate_t lo,
		input flight_pkg::rate_t hi
	);
		if (val > hi)
			return hi;
		else if (val < lo)
			return lo;
		else
			return val;
	endfunction

	// sequencer, a start while busy is dropped
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
		end else begin
			case (state)
				ST_WAITING:  if (start) state <= ST_MAPPING;
				ST_MAPPING:  state <= ST_SCALING;
				ST_SCALING:  state <= ST_LIMITING;
				ST_LIMITING: state <= ST_WRITING;
				ST_WRITING:  if (wr_rsp.ack) state <= ST_WAITING;
				default:     state <= ST_WAITING;
			endcase
		end
	end

	// datapath, one stage per state
	always_ff @(posedge us_clk) begin
		if (state == ST_WAITING && start) begin
			tgt_q <= targets;
			att_q <= attitude;
		end
		if (state == ST_MAPPING) begin
			map_thr   <= $signed({20'd0, tgt_q.throttle, 4'd0});
			map_yaw   <= ($signed({24'd0, tgt_q.yaw}) - flight_pkg::YAW_CENTER) * 16;
			map_pitch <= $signed({24'd0, tgt_q.pitch}) * 4 - flight_pkg::MAP_OFFSET
				- att_q.pitch;
			// IMU roll sign is flipped, so add it
			map_roll  <= $signed({24'd0, tgt_q.roll}) * 4 - flight_pkg::MAP_OFFSET
				+ att_q.roll;
		end
		if (state == ST_SCALING) begin
			scaled_q.throttle <= scale_sat(map_thr, flight_pkg::THROTTLE_MULT,
				flight_pkg::THROTTLE_SHIFT);
			scaled_q.yaw   <= scale_sat(map_yaw, flight_pkg::YAW_MULT, flight_pkg::YAW_SHIFT);
			scaled_q.pitch <= scale_sat(map_pitch, flight_pkg::PITCH_MULT,
				flight_pkg::PITCH_SHIFT);
			scaled_q.roll  <= scale_sat(map_roll, flight_pkg::ROLL_MULT, flight_pkg::ROLL_SHIFT);
		end
		if (state == ST_LIMITING) begin
			limit_q.throttle <= clamp_rate(scaled_q.throttle, 16'sd0, flight_pkg::THROTTLE_MAX);
			limit_q.yaw   <= clamp_rate(scaled_q.yaw, -flight_pkg::RATE_LIMIT,
				flight_pkg::RATE_LIMIT);
			limit_q.pitch <= clamp_rate(scaled_q.pitch, -flight_pkg::RATE_LIMIT,
				flight_pkg::RATE_LIMIT);
			limit_q.roll  <= clamp_rate(scaled_q.roll, -flight_pkg::RATE_LIMIT,
				flight_pkg::RATE_LIMIT);
		end
	end

	// record held steady until ack
	assign wr_req.cyc = (state == ST_WRITING);
	assign wr_req.stb = (state == ST_WRITING);
	assign wr_req.we  = 1'b1;
	assign wr_req.dat = limit_q;

	assign busy = (state != ST_WAITING);

endmodule

`default_nettype wire

/* design/flight_ctrl_top.sv */
// attitude stage top level
// angle controller -> setpoint FIFO -> motor mixer
`default_nettype none

module flight_ctrl_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int MOTOR_MAX  = 4095
) (
	input  wire logic                  us_clk,
	input  wire logic                  resetn,
	input  wire logic                  start,
	input  wire flight_pkg::target_t   targets,
	input  wire flight_pkg::attitude_t attitude,
	input  wire logic                  armed,
	output flight_pkg::motor_cmd_t     motors,
	output logic                       motor_valid,
	output logic                       busy
);

	flight_pkg::wb_req_t wr_req, rd_req;
	flight_pkg::wb_rsp_t wr_rsp, rd_rsp;

	angle_controller u_angle_controller (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.start    (start),
		.targets  (targets),
		.attitude (attitude),
		.wr_req   (wr_req),
		.wr_rsp   (wr_rsp),
		.busy     (busy)
	);

	setpoint_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_setpoint_fifo (
		.us_clk (us_clk),
		.resetn (resetn),
		.wr_req (wr_req),
		.wr_rsp (wr_rsp),
		.rd_req (rd_req),
		.rd_rsp (rd_rsp)
	);

	motor_mixer #(.MOTOR_MAX(MOTOR_MAX)) u_motor_mixer (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.armed       (armed),
		.rd_req      (rd_req),
		.rd_rsp      (rd_rsp),
		.motors      (motors),
		.motor_valid (motor_valid)
	);

endmodule

`default_nettype wire

/* design/flight_pkg.sv */
// shared widths and fixed-point types for the attitude stage
// setpoint, motor and Wishbone request/response structs
// rate limits, mapping offsets and per-axis scale constants
`default_nettype none

package flight_pkg;

	// receiver target, 0..255
	typedef logic [7:0] rec_val_t;

	// signed 12.4 fixed point, rates and IMU angles
	typedef logic signed [15:0] rate_t;

	// unsigned motor command
	typedef logic [11:0] motor_val_t;

	typedef struct packed {
		rec_val_t throttle;
		rec_val_t yaw;
		rec_val_t pitch;
		rec_val_t roll;
	} target_t;

	typedef struct packed {
		rate_t pitch;
		rate_t roll;
	} attitude_t;

	// one rate setpoint record, as stored in the FIFO
	typedef struct packed {
		rate_t throttle;
		rate_t yaw;
		rate_t pitch;
		rate_t roll;
	} rate_set_t;

	typedef struct packed {
		motor_val_t front_left;
		motor_val_t front_right;
		motor_val_t rear_left;
		motor_val_t rear_right;
	} motor_cmd_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		rate_set_t dat;
	} wb_req_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic      ack;
		rate_set_t dat;
	} wb_rsp_t;

	// rate limits in 12.4, 250 and 100
	localparam rate_t THROTTLE_MAX = 16'sd4000;
	localparam rate_t RATE_LIMIT   = 16'sd1600;

	// stick mapping
	localparam int MAP_OFFSET = 500;
	localparam int YAW_CENTER = 125;

	// scale = (val * mult) >>> shift
	localparam int THROTTLE_MULT  = 1;
	localparam int THROTTLE_SHIFT = 0;
	localparam int YAW_MULT       = 4;
	localparam int YAW_SHIFT      = 0;
	localparam int PITCH_MULT     = 3;
	localparam int PITCH_SHIFT    = 1;
	localparam int ROLL_MULT      = 3;
	localparam int ROLL_SHIFT     = 1;

endpackage

`default_nettype wire

/* design/motor_mixer.sv */
// motor mixer: Wishbone read master pulling rate setpoints while armed
// quad-X mix into four motor commands, clamped to 0..MOTOR_MAX
`default_nettype none

module motor_mixer #(
	parameter int MOTOR_MAX = 4095
) (
	input  wire logic                us_clk,
	input  wire logic                resetn,
	input  wire logic                armed,
	output flight_pkg::wb_req_t      rd_req,
	input  wire flight_pkg::wb_rsp_t rd_rsp,
	output flight_pkg::motor_cmd_t   motors,
	output logic                     motor_valid
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_FETCH,
		M_MIX
	} state_t;

	state_t state;

	flight_pkg::rate_set_t rec_q;
	flight_pkg::rate_t     thr, yaw, pitch, roll;
	logic signed [17:0]    sum_fl, sum_fr, sum_rl, sum_rr;

	function automatic flight_pkg::motor_val_t clamp_motor(input logic signed [17:0] s);
		if (s < 18'sd0)
			return '0;
		else if (s > MOTOR_MAX)
			return flight_pkg::motor_val_t'(MOTOR_MAX);
		else
			return s[11:0];
	endfunction

	assign thr   = rec_q.throttle;
	assign yaw   = rec_q.yaw;
	assign pitch = rec_q.pitch;
	assign roll  = rec_q.roll;

	// quad-X mix
	assign sum_fl = thr + pitch + roll - yaw;
	assign sum_fr = thr + pitch - roll + yaw;
	assign sum_rl = thr - pitch + roll + yaw;
	assign sum_rr = thr - pitch - roll - yaw;

	// strobe stays up until ack, even if armed drops meanwhile
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state       <= M_IDLE;
			motors      <= '0;
			motor_valid <= 1'b0;
		end else begin
			motor_valid <= (state == M_MIX);
			case (state)
				M_IDLE:  if (armed) state <= M_FETCH;
				M_FETCH: if (rd_rsp.ack) state <= M_MIX;
				M_MIX: begin
					motors.front_left  <= clamp_motor(sum_fl);
					motors.front_right <= clamp_motor(sum_fr);
					motors.rear_left   <= clamp_motor(sum_rl);
					motors.rear_right  <= clamp_motor(sum_rr);
					state <= M_IDLE;
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == M_FETCH && rd_rsp.ack)
			rec_q <= rd_rsp.dat;
	end

	assign rd_req.cyc = (state == M_FETCH);
	assign rd_req.stb = (state == M_FETCH);
	assign rd_req.we  = 1'b0;
	assign rd_req.dat = '0;

	a_valid_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
		motor_valid |=> !motor_valid);

endmodule

`default_nettype wire

/* design/setpoint_fifo.sv */
// rate setpoint FIFO between the angle controller and the mixer
// Wishbone classic slave ports, one for writes and one for reads
`default_nettype none

module setpoint_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                us_clk,
	input  wire logic                resetn,
	input  wire flight_pkg::wb_req_t wr_req,
	output flight_pkg::wb_rsp_t      wr_rsp,
	input  wire flight_pkg::wb_req_t rd_req,
	output flight_pkg::wb_rsp_t      rd_rsp
);

	// depth must be a power of two so the pointers wrap by themselves
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	flight_pkg::rate_set_t mem [FIFO_DEPTH];
	flight_pkg::rate_set_t rd_dat;

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_ack, rd_ack;
	logic             full, empty;
	logic             wr_go, rd_go;

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);

	// accept only on a fresh strobe, not in the ack cycle
	assign wr_go = wr_req.cyc && wr_req.stb && wr_req.we && !wr_ack && !full;
	assign rd_go = rd_req.cyc && rd_req.stb && !rd_req.we && !rd_ack && !empty;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			wr_ack <= wr_go;
			rd_ack <= rd_go;
			if (wr_go)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_go)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_go, rd_go})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge us_clk) begin
		if (wr_go)
			mem[wr_ptr] <= wr_req.dat;
		if (rd_go)
			rd_dat <= mem[rd_ptr];
	end

	assign wr_rsp.ack = wr_ack;
	assign wr_rsp.dat = '0;
	assign rd_rsp.ack = rd_ack;
	assign rd_rsp.dat = rd_dat;

	a_count_max: assert property (@(posedge us_clk) disable iff (!resetn)
		count <= CNT_W'(FIFO_DEPTH));

	// masters must still hold their strobe when the ack lands
	a_wr_ack_stb: assert property (@(posedge us_clk) disable iff (!resetn)
		wr_rsp.ack |-> wr_req.cyc && wr_req.stb);
	a_rd_ack_stb: assert property (@(posedge us_clk) disable iff (!resetn)
		rd_rsp.ack |-> rd_req.cyc && rd_req.stb);

endmodule

`default_nettype wire

/* tests/flight_ctrl_tb.sv */
// testbench for the attitude stage top level
// stimulus table with reference model, result queue, LFSR rows and timeout
`default_nettype none

module flight_ctrl_tb;

	localparam int FIFO_DEPTH = 4;
	localparam int MOTOR_MAX  = 4095;
	localparam int NUM_RANDOM = 8;

	typedef struct packed {
		logic [2:0]             test_id;
		logic                   armed;
		flight_pkg::target_t    tgt;
		flight_pkg::attitude_t  att;
		flight_pkg::motor_cmd_t exp;
	} row_t;

	logic                   us_clk = 1'b0;
	logic                   resetn;
	logic                   start;
	flight_pkg::target_t    targets;
	flight_pkg::attitude_t  attitude;
	logic                   armed;
	flight_pkg::motor_cmd_t motors;
	logic                   motor_valid;
	logic                   busy;

	row_t                   rows[$];
	flight_pkg::motor_cmd_t exp_q[$];
	logic [15:0]            lfsr = 16'd38;
	int                     cycles = 0;
	int                     cycle_limit = 1000;
	int                     errors = 0;
	int                     valid_count = 0;
	int                     tests = 0;
	int                     tests_failed = 0;
	int                     g_valid;
	int                     g_pushed;
	int                     g_errors;

	flight_ctrl_top #(.FIFO_DEPTH(FIFO_DEPTH), .MOTOR_MAX(MOTOR_MAX)) DUT (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (start),
		.targets     (targets),
		.attitude    (attitude),
		.armed       (armed),
		.motors      (motors),
		.motor_valid (motor_valid),
		.busy        (busy)
	);

	always #10 us_clk = ~us_clk;

	function automatic int clamp_int(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	// multiply, arithmetic shift, saturate to the 16-bit signed range
	function automatic flight_pkg::rate_t scaled_axis(input int v, input int mult, input int shift);
		int p;
		p = (v * mult) >>> shift;
		return flight_pkg::rate_t'(clamp_int(p, -32768, 32767));
	endfunction

	function automatic flight_pkg::rate_set_t model_rates(input flight_pkg::target_t t,
		input flight_pkg::attitude_t a);
		int thr;
		int yaw;
		int pitch;
		int roll;
		int imu_p;
		int imu_r;
		int lim;
		flight_pkg::rate_set_t r;
		imu_p = a.pitch;
		imu_r = a.roll;
		lim = flight_pkg::RATE_LIMIT;
		thr = int'(t.throttle) * 16;
		yaw = (int'(t.yaw) - flight_pkg::YAW_CENTER) * 16;
		pitch = int'(t.pitch) * 4 - flight_pkg::MAP_OFFSET - imu_p;
		// roll sign from the IMU is flipped
		roll = int'(t.roll) * 4 - flight_pkg::MAP_OFFSET + imu_r;
		thr = scaled_axis(thr, flight_pkg::THROTTLE_MULT, flight_pkg::THROTTLE_SHIFT);
		yaw = scaled_axis(yaw, flight_pkg::YAW_MULT, flight_pkg::YAW_SHIFT);
		pitch = scaled_axis(pitch, flight_pkg::PITCH_MULT, flight_pkg::PITCH_SHIFT);
		roll = scaled_axis(roll, flight_pkg::ROLL_MULT, flight_pkg::ROLL_SHIFT);
		r.throttle = flight_pkg::rate_t'(clamp_int(thr, 0, flight_pkg::THROTTLE_MAX));
		r.yaw = flight_pkg::rate_t'(clamp_int(yaw, -lim, lim));
		r.pitch = flight_pkg::rate_t'(clamp_int(pitch, -lim, lim));
		r.roll = flight_pkg::rate_t'(clamp_int(roll, -lim, lim));
		return r;
	endfunction

	// quad-X mix
	function automatic flight_pkg::motor_cmd_t model_motors(input flight_pkg::rate_set_t r);
		int t;
		int y;
		int p;
		int l;
		flight_pkg::motor_cmd_t m;
		t = r.throttle;
		y = r.yaw;
		p = r.pitch;
		l = r.roll;
		m.front_left = flight_pkg::motor_val_t'(clamp_int(t + p + l - y, 0, MOTOR_MAX));
		m.front_right = flight_pkg::motor_val_t'(clamp_int(t + p - l + y, 0, MOTOR_MAX));
		m.rear_left = flight_pkg::motor_val_t'(clamp_int(t - p + l + y, 0, MOTOR_MAX));
		m.rear_right = flight_pkg::motor_val_t'(clamp_int(t - p - l - y, 0, MOTOR_MAX));
		return m;
	endfunction

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "nominal mapping";
			3'd2:    return "limits";
			3'd3:    return "imu sign";
			3'd4:    return "back-pressure";
			default: return "random rows";
		endcase
	endfunction

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hb400;
		else
			return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic compare_motor(input flight_pkg::motor_cmd_t got,
		input flight_pkg::motor_cmd_t exp);
		if (got !== exp) begin
			errors++;
			$display("error motors: got %h expected %h", got, exp);
		end
	endtask

	task automatic compare_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic add_row(input int id, input int arm, input int thr, input int yaw,
		input int pitch, input int roll, input int imu_p, input int imu_r);
		row_t r;
		r.test_id = 3'(id);
		r.armed = 1'(arm);
		r.tgt.throttle = flight_pkg::rec_val_t'(thr);
		r.tgt.yaw = flight_pkg::rec_val_t'(yaw);
		r.tgt.pitch = flight_pkg::rec_val_t'(pitch);
		r.tgt.roll = flight_pkg::rec_val_t'(roll);
		r.att.pitch = flight_pkg::rate_t'(imu_p);
		r.att.roll = flight_pkg::rate_t'(imu_r);
		r.exp = model_motors(model_rates(r.tgt, r.att));
		rows.push_back(r);
	endtask

	task automatic build_table();
		int i;
		int imu_p;
		int imu_r;
		logic [31:0] v;
		logic [31:0] a;
		// disarmed, one more than the FIFO holds
		add_row(4, 0, 100, 125, 125, 125, 0, 0);
		add_row(4, 0, 120, 130, 140, 110, 16, -16);
		add_row(4, 0, 80, 100, 125, 150, -40, 24);
		add_row(4, 0, 200, 125, 90, 125, 0, 64);
		add_row(4, 0, 60, 140, 125, 100, 32, 0);
		add_row(1, 1, 100, 125, 125, 125, 0, 0);
		// throttle 0 and 4000, rates and motors at both ends
		add_row(2, 1, 0, 125, 125, 125, 0, 0);
		add_row(2, 1, 255, 125, 125, 125, 0, 0);
		add_row(2, 1, 255, 0, 255, 255, 0, 0);
		add_row(2, 1, 0, 255, 125, 125, -32768, 32767);
		add_row(2, 1, 200, 0, 0, 0, 32767, -32768);
		add_row(3, 1, 100, 125, 125, 125, 160, 0);
		add_row(3, 1, 100, 125, 125, 125, 0, 160);
		for (i = 0; i < NUM_RANDOM; i++) begin
			rand_bits(32, v);
			rand_bits(10, a);
			imu_p = $signed(a[9:0]);
			rand_bits(10, a);
			imu_r = $signed(a[9:0]);
			add_row(6, 1, v[31:24], v[23:16], v[15:8], v[7:0], imu_p, imu_r);
		end
	endtask

	task automatic pulse_start(input flight_pkg::target_t t, input flight_pkg::attitude_t a,
		input logic arm);
		@(posedge us_clk);
		targets  <= t;
		attitude <= a;
		armed    <= arm;
		start    <= 1'b1;
		@(posedge us_clk);
		start <= 1'b0;
	endtask

	task automatic begin_test();
		g_valid = valid_count;
		g_pushed = 0;
		g_errors = errors;
	endtask

	task automatic finish_test(input string name);
		while (exp_q.size() != 0)
			@(posedge us_clk);
		repeat (12) @(posedge us_clk);
		if (valid_count - g_valid != g_pushed) begin
			errors++;
			$display("%s: %0d results came out, %0d expected", name,
				valid_count - g_valid, g_pushed);
		end
		tests++;
		if (errors != g_errors) begin
			tests_failed++;
			$display("test %s failed, %0d errors", name, errors - g_errors);
		end else begin
			$display("test %s passed", name);
		end
	endtask

	task automatic apply_row(input row_t r);
		logic full;
		full = !r.armed && exp_q.size() == FIFO_DEPTH;
		exp_q.push_back(r.exp);
		g_pushed++;
		pulse_start(r.tgt, r.att, r.armed);
		@(posedge us_clk);
		compare_level("busy", busy, 1'b1);
		if (full) begin
			// writer must stall on the full FIFO
			repeat (20) @(posedge us_clk);
			compare_level("busy", busy, 1'b1);
			if (valid_count != g_valid) begin
				errors++;
				$display("motor_valid appeared while disarmed");
			end
			armed <= 1'b1;
		end
		while (busy)
			@(posedge us_clk);
	endtask

	// each result pops the oldest expected entry
	always @(posedge us_clk) begin
		if (resetn && motor_valid) begin
			valid_count++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("motor_valid pulsed with no result pending");
			end else begin
				compare_motor(motors, exp_q.pop_front());
			end
		end
	end

	always @(posedge us_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d results pending", cycles, exp_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [2:0] cur_id;
		flight_pkg::target_t t1;
		flight_pkg::target_t t2;
		flight_pkg::attitude_t a1;
		resetn = 1'b0;
		start = 1'b0;
		targets = '0;
		attitude = '0;
		armed = 1'b0;
		build_table();
		cycle_limit = 40 * (rows.size() + 1) + 200;
		repeat (2) @(posedge us_clk);
		resetn <= 1'b1;

		begin_test();
		@(posedge us_clk);
		compare_motor(motors, '0);
		compare_level("busy", busy, 1'b0);
		compare_level("motor_valid", motor_valid, 1'b0);
		finish_test("reset state");

		cur_id = rows[0].test_id;
		begin_test();
		foreach (rows[i]) begin
			if (rows[i].test_id != cur_id) begin
				finish_test(test_name(cur_id));
				cur_id = rows[i].test_id;
				begin_test();
			end
			apply_row(rows[i]);
		end
		finish_test(test_name(cur_id));

		// second start lands in the scaling stage and must be dropped
		t1 = {8'd150, 8'd140, 8'd110, 8'd130};
		t2 = {8'd30, 8'd10, 8'd240, 8'd20};
		a1 = {16'sd32, -16'sd48};
		begin_test();
		exp_q.push_back(model_motors(model_rates(t1, a1)));
		g_pushed++;
		pulse_start(t1, a1, 1'b1);
		@(posedge us_clk);
		targets <= t2;
		start   <= 1'b1;
		@(posedge us_clk);
		start <= 1'b0;
		@(posedge us_clk);
		while (busy)
			@(posedge us_clk);
		finish_test("start while busy");

		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/flight_pkg.sv
design/angle_controller.sv
design/setpoint_fifo.sv
design/motor_mixer.sv
design/flight_ctrl_top.sv
tests/flight_ctrl_tb.sv
